// File: src/exec_defs.svh
// Shared widths, tile geometry, APB register map and opcodes of the execution unit
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// ========================================
// Tile geometry
// ========================================

// One signed element
`define ELEM_W 8

// Elements per tile, also the matrix row and column count
`define TILE_N 4

// Vector buffers in the buffer file
`define VEC_BUFS 4

// ========================================
// APB register map (byte addresses)
// ========================================

// Vector buffers 0-3, read and write
`define ADDR_VEC 8'h00
// Matrix rows 0-3, write only
`define ADDR_MAT 8'h10
// A write here issues a command
`define ADDR_CMD 8'h20
// Bit 0 is busy
`define ADDR_STAT 8'h24

// ========================================
// Opcodes
// ========================================

`define OP_NOP 5'd0
`define OP_GEMV 5'd4
`define OP_RELU 5'd5

`endif

// File: src/exec_pkg.sv
// Tile, command and completion types plus the element saturation helper
`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

    // One signed element and a tile of them, element 0 in the low byte
    typedef logic signed [`ELEM_W-1:0] elem_t;
    typedef elem_t [`TILE_N-1:0] tile_t;

    typedef logic [1:0] buf_id_t;
    typedef logic [4:0] opcode_t;

    // Command word fields: opcode 4:0, dest 9:8, x_id 13:12, b_id 17:16
    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        buf_id_t dest;
        buf_id_t x_id;
        buf_id_t b_id;
    } cmd_t;

    // One finished command
    typedef struct packed {
        logic  valid;
        logic  err;
        tile_t tile;
    } cmpl_t;

    localparam int ELEM_MAX = 2 ** (`ELEM_W - 1) - 1;
    localparam int ELEM_MIN = -(2 ** (`ELEM_W - 1));

    // Clamp a wide accumulator into one element
    function automatic elem_t sat_elem(input logic signed [31:0] sum);
        if (sum > ELEM_MAX) begin
            return elem_t'(ELEM_MAX);
        end else if (sum < ELEM_MIN) begin
            return elem_t'(ELEM_MIN);
        end
        return sum[`ELEM_W-1:0];
    endfunction

endpackage

`default_nettype wire

// File: src/tile_bus_if.sv
// Buffer traffic interfaces for the host side and the compute engine side
`default_nettype none

// Host loads and readbacks into the buffer file
interface host_buf_if;

    logic              we;
    logic              is_mat;
    exec_pkg::buf_id_t idx;
    exec_pkg::tile_t   wtile;
    exec_pkg::buf_id_t ridx;
    exec_pkg::tile_t   rtile;

    modport host (
        output we, is_mat, idx, wtile, ridx,
        input  rtile
    );

    modport mem (
        input  we, is_mat, idx, wtile, ridx,
        output rtile
    );

endinterface

// Operand fetch and result write-back for the engine
interface eng_buf_if;

    exec_pkg::buf_id_t x_id;
    exec_pkg::buf_id_t b_id;
    exec_pkg::buf_id_t row;
    logic              we;
    exec_pkg::buf_id_t dest;
    exec_pkg::tile_t   wtile;
    exec_pkg::tile_t   x_tile;
    exec_pkg::tile_t   b_tile;
    exec_pkg::tile_t   row_tile;

    modport core (
        output x_id, b_id, row, we, dest, wtile,
        input  x_tile, b_tile, row_tile
    );

    modport mem (
        input  x_id, b_id, row, we, dest, wtile,
        output x_tile, b_tile, row_tile
    );

endinterface

`default_nettype wire

// File: src/apb_cmd_port.sv
// APB slave that decodes tile loads, vector readbacks, status and command writes
`default_nettype none

`include "exec_defs.svh"

module apb_cmd_port import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        busy,
    output cmd_t        cmd,
    host_buf_if.host    hb
);

    logic access;
    logic aligned;
    logic sel_vec;
    logic sel_mat;
    logic sel_cmd;
    logic sel_stat;
    logic bad;
    logic cmd_wr;

    // ========================================
    // Address decode
    // ========================================

    // Zero wait states, every transfer is setup plus one access cycle
    assign pready = 1'b1;
    assign access = psel & penable;

    assign aligned  = (paddr[1:0] == 2'b00);
    assign sel_vec  = aligned && ((paddr & 8'hF0) == `ADDR_VEC);
    assign sel_mat  = aligned && ((paddr & 8'hF0) == `ADDR_MAT);
    assign sel_cmd  = (paddr == `ADDR_CMD);
    assign sel_stat = (paddr == `ADDR_STAT);

    // Unmapped, wrong direction, or a write that would disturb a running command
    always_comb begin
        bad = 1'b0;
        if (!(sel_vec || sel_mat || sel_cmd || sel_stat)) begin
            bad = 1'b1;
        end else if (pwrite) begin
            bad = sel_stat || (busy && (sel_vec || sel_mat || sel_cmd));
        end else begin
            bad = sel_mat || sel_cmd;
        end
    end

    assign pslverr = access & bad;

    // ========================================
    // Buffer load and readback
    // ========================================

    assign hb.we     = access & pwrite & ~bad & (sel_vec | sel_mat);
    assign hb.is_mat = sel_mat;
    assign hb.idx    = paddr[3:2];
    assign hb.wtile  = pwdata;
    assign hb.ridx   = paddr[3:2];

    always_comb begin
        prdata = '0;
        if (sel_vec) begin
            prdata = hb.rtile;
        end else if (sel_stat) begin
            prdata = {31'b0, busy};
        end
    end

    // ========================================
    // Command issue
    // ========================================

    assign cmd_wr = access & pwrite & ~bad & sel_cmd;

    // Pulse goes out the cycle after the access edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd <= '0;
        end else begin
            cmd.valid <= cmd_wr;
            if (cmd_wr) begin
                cmd.opcode <= pwdata[4:0];
                cmd.dest   <= pwdata[9:8];
                cmd.x_id   <= pwdata[13:12];
                cmd.b_id   <= pwdata[17:16];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/buffer_file.sv
// Vector and matrix tile storage with a host port and an engine port
`default_nettype none

`include "exec_defs.svh"

module buffer_file import exec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    host_buf_if.mem hb,
    eng_buf_if.mem  eb
);

    tile_t vec_q [`VEC_BUFS];
    tile_t mat_q [`TILE_N];

    // ========================================
    // Storage
    // ========================================

    // Host writes land only while idle and engine writes only while busy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `VEC_BUFS; i++) begin
                vec_q[i] <= '0;
            end
            for (int r = 0; r < `TILE_N; r++) begin
                mat_q[r] <= '0;
            end
        end else begin
            if (hb.we) begin
                if (hb.is_mat) begin
                    mat_q[hb.idx] <= hb.wtile;
                end else begin
                    vec_q[hb.idx] <= hb.wtile;
                end
            end
            if (eb.we) begin
                vec_q[eb.dest] <= eb.wtile;
            end
        end
    end

    // ========================================
    // Read muxes
    // ========================================

    // Host readback of a vector tile
    assign hb.rtile = vec_q[hb.ridx];

    // Engine operands
    assign eb.x_tile   = vec_q[eb.x_id];
    assign eb.b_tile   = vec_q[eb.b_id];
    assign eb.row_tile = mat_q[eb.row];

endmodule

`default_nettype wire

// File: src/exec_core.sv
// Command dispatch with the row-serial GEMV datapath and a single-cycle ReLU
`default_nettype none

`include "exec_defs.svh"

module exec_core import exec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  cmd_t    cmd,
    output logic    busy,
    eng_buf_if.core eb,
    output cmpl_t   cmpl
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SINGLE,
        ST_GEMV,
        ST_WB
    } state_t;

    state_t  state;
    opcode_t cur_op;
    buf_id_t cur_dest;
    buf_id_t cur_x;
    buf_id_t cur_b;
    buf_id_t row;
    tile_t   acc;
    tile_t   relu_tile;
    logic    known_op;
    logic    cmpl_valid;
    logic    cmpl_err;
    logic signed [31:0] row_sum;

    // ========================================
    // Datapath
    // ========================================

    always_comb begin
        for (int i = 0; i < `TILE_N; i++) begin
            relu_tile[i] = eb.x_tile[i][`ELEM_W-1] ? '0 : eb.x_tile[i];
        end
    end

    // b[row] plus the dot product of W row and x
    always_comb begin
        row_sum = 32'($signed(eb.b_tile[row]));
        for (int c = 0; c < `TILE_N; c++) begin
            row_sum = row_sum + $signed(eb.row_tile[c]) * $signed(eb.x_tile[c]);
        end
    end

    assign known_op = (cur_op == `OP_NOP) || (cur_op == `OP_RELU);

    assign eb.x_id  = cur_x;
    assign eb.b_id  = cur_b;
    assign eb.row   = row;
    assign eb.dest  = cur_dest;
    assign eb.we    = (state == ST_WB) || (state == ST_SINGLE && cur_op == `OP_RELU);
    assign eb.wtile = (state == ST_WB) ? acc : relu_tile;

    // acc keeps the last produced tile, so a NOP reports it unchanged
    assign cmpl = '{valid: cmpl_valid, err: cmpl_err, tile: acc};

    // ========================================
    // Control FSM
    // ========================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            busy       <= 1'b0;
            cur_op     <= `OP_NOP;
            cur_dest   <= '0;
            cur_x      <= '0;
            cur_b      <= '0;
            row        <= '0;
            acc        <= '0;
            cmpl_valid <= 1'b0;
            cmpl_err   <= 1'b0;
        end else begin
            cmpl_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd.valid) begin
                        cur_op   <= cmd.opcode;
                        cur_dest <= cmd.dest;
                        cur_x    <= cmd.x_id;
                        cur_b    <= cmd.b_id;
                        row      <= '0;
                        busy     <= 1'b1;
                        state    <= (cmd.opcode == `OP_GEMV) ? ST_GEMV : ST_SINGLE;
                    end
                end
                // NOP, RELU and unknown opcodes all finish here
                ST_SINGLE: begin
                    if (cur_op == `OP_RELU) begin
                        acc <= relu_tile;
                    end
                    cmpl_valid <= 1'b1;
                    cmpl_err   <= !known_op;
                    busy       <= 1'b0;
                    state      <= ST_IDLE;
                end
                // One output row per cycle
                ST_GEMV: begin
                    acc[row] <= sat_elem(row_sum);
                    row      <= row + 2'd1;
                    if (row == buf_id_t'(`TILE_N - 1)) begin
                        state <= ST_WB;
                    end
                end
                ST_WB: begin
                    cmpl_valid <= 1'b1;
                    cmpl_err   <= 1'b0;
                    busy       <= 1'b0;
                    state      <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/result_port.sv
// Output stage holding the last result tile, the done pulse and the error flag
`default_nettype none

module result_port import exec_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  cmpl_t cmpl,
    output tile_t result,
    output logic  done,
    output logic  err
);

    // done follows each completion by one edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
            done   <= 1'b0;
            err    <= 1'b0;
        end else begin
            done <= cmpl.valid;
            if (cmpl.valid) begin
                err <= cmpl.err;
                // A failed command leaves the previous tile visible
                if (!cmpl.err) begin
                    result <= cmpl.tile;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/exec_unit_top.sv
// Top level of the tiled execution unit with an APB host port
`default_nettype none

module exec_unit_top import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // APB slave
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,

    // Completion
    output tile_t       result,
    output logic        done,
    output logic        err
);

    cmd_t  cmd;
    cmpl_t cmpl;
    logic  busy;

    host_buf_if hb ();
    eng_buf_if  eb ();

    // ========================================
    // Host side
    // ========================================

    apb_cmd_port apb_cmd_port_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .busy    (busy),
        .cmd     (cmd),
        .hb      (hb.host)
    );

    // ========================================
    // Storage and compute
    // ========================================

    buffer_file buffer_file_i (
        .clk (clk),
        .rst (rst),
        .hb  (hb.mem),
        .eb  (eb.mem)
    );

    exec_core exec_core_i (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd),
        .busy (busy),
        .eb   (eb.core),
        .cmpl (cmpl)
    );

    // Output registers
    result_port result_port_i (
        .clk    (clk),
        .rst    (rst),
        .cmpl   (cmpl),
        .result (result),
        .done   (done),
        .err    (err)
    );

endmodule

`default_nettype wire

// File: verif/exec_tests.svh
// Directed tests and reference model of the execution unit, included into the testbench

// ========================================
// Reference model
// ========================================

function automatic elem_t clamp_ref(input int s);
    if (s > 127) begin
        return 8'sh7F;
    end
    if (s < -128) begin
        return 8'sh80;
    end
    return elem_t'(s);
endfunction

// y[r] = clamp(b[r] + sum over c of W[r][c] * x[c])
function automatic tile_t gemv_ref(input tile_t x, input tile_t b);
    tile_t y;
    int    s;
    for (int r = 0; r < `TILE_N; r++) begin
        s = int'(b[r]);
        for (int c = 0; c < `TILE_N; c++) begin
            s += int'(mat_m[r][c]) * int'(x[c]);
        end
        y[r] = clamp_ref(s);
    end
    return y;
endfunction

function automatic tile_t relu_ref(input tile_t x);
    tile_t y;
    for (int i = 0; i < `TILE_N; i++) begin
        y[i] = (x[i] < 0) ? elem_t'(0) : x[i];
    end
    return y;
endfunction

task automatic expect_result(input tile_t exp, input buf_id_t dest);
    check_tile("result", result, exp);
    check_bit("err", err, 1'b0);
    vec_m[dest] = exp;
    last_result = exp;
    read_vec_check(dest);
endtask

// ========================================
// Tests
// ========================================

task automatic test_load_readback();
    logic [31:0] stat;
    logic        slverr;
    apb_read(`ADDR_STAT, stat, slverr);
    check_bit("pslverr", slverr, 1'b0);
    check_word("status", stat, 32'h0);
    check_tile("result", result, last_result);
    check_bit("err", err, 1'b0);
    check_bit("done", done, 1'b0);
    read_vec_check(2'd0);
    for (int i = 0; i < `VEC_BUFS; i++) begin
        load_vec(buf_id_t'(i), tile_t'($random(seed)));
    end
    for (int i = 0; i < `VEC_BUFS; i++) begin
        read_vec_check(buf_id_t'(i));
    end
endtask

task automatic test_relu();
    // Element 0 sits in the low byte
    load_vec(2'd1, {8'sh7F, 8'sh80, 8'sh05, 8'shFF});
    run_cmd(`OP_RELU, 2'd2, 2'd1, 2'd0);
    expect_result(relu_ref(vec_m[1]), 2'd2);
endtask

task automatic test_gemv();
    // Rows 0 and 1 push the sums past both rails
    load_mat(2'd0, {4{8'sh7F}});
    load_mat(2'd1, {4{8'sh80}});
    load_mat(2'd2, tile_t'($random(seed)));
    load_mat(2'd3, tile_t'($random(seed)));
    load_vec(2'd0, {8'sh7F, 8'sh64, 8'sh50, 8'sh7F});
    load_vec(2'd3, tile_t'($random(seed)));
    run_cmd(`OP_GEMV, 2'd1, 2'd0, 2'd3);
    expect_result(gemv_ref(vec_m[0], vec_m[3]), 2'd1);
endtask

task automatic test_chain();
    run_cmd(`OP_RELU, 2'd2, 2'd1, 2'd0);
    expect_result(relu_ref(vec_m[1]), 2'd2);
    run_cmd(`OP_GEMV, 2'd0, 2'd2, 2'd3);
    expect_result(gemv_ref(vec_m[2], vec_m[3]), 2'd0);
endtask

// GEMV into buffer 1 with one write attempted while it runs
task automatic reject_while_busy(input logic [7:0] addr, input logic [31:0] data);
    logic  slverr;
    tile_t exp;
    exp = gemv_ref(vec_m[0], vec_m[3]);
    apb_write(`ADDR_CMD, cmd_word(`OP_GEMV, 2'd1, 2'd0, 2'd3), slverr);
    check_bit("pslverr", slverr, 1'b0);
    apb_write(addr, data, slverr);
    check_bit("pslverr", slverr, 1'b1);
    wait_done();
    expect_result(exp, 2'd1);
endtask

task automatic test_errors();
    logic        slverr;
    logic [31:0] word;
    run_cmd(5'd3, 2'd0, 2'd0, 2'd0);
    check_bit("err", err, 1'b1);
    check_tile("result", result, last_result);
    run_cmd(`OP_NOP, 2'd0, 2'd0, 2'd0);
    check_bit("err", err, 1'b0);
    check_tile("result", result, last_result);
    // Status reads stay allowed while a GEMV runs
    apb_write(`ADDR_CMD, cmd_word(`OP_GEMV, 2'd1, 2'd0, 2'd3), slverr);
    check_bit("pslverr", slverr, 1'b0);
    apb_read(`ADDR_STAT, word, slverr);
    check_bit("pslverr", slverr, 1'b0);
    check_word("status", word, 32'h1);
    wait_done();
    expect_result(gemv_ref(vec_m[0], vec_m[3]), 2'd1);
    reject_while_busy(`ADDR_VEC, 32'hA5A5_A5A5);
    reject_while_busy(`ADDR_MAT + 8'h08, 32'h7F7F_7F7F);
    reject_while_busy(`ADDR_CMD, cmd_word(`OP_RELU, 2'd0, 2'd1, 2'd0));
    read_vec_check(2'd0);
    // Unmapped address and a read of the write-only matrix
    apb_write(8'h30, 32'h1234_5678, slverr);
    check_bit("pslverr", slverr, 1'b1);
    apb_read(8'h30, word, slverr);
    check_bit("pslverr", slverr, 1'b1);
    apb_read(`ADDR_MAT, word, slverr);
    check_bit("pslverr", slverr, 1'b1);
endtask

// File: verif/exec_tb.sv
// Testbench for the execution unit with an APB driver, compare tasks and directed tests
`default_nettype none

`include "exec_defs.svh"

module exec_tb import exec_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    tile_t       result;
    logic        done;
    logic        err;

    // Model of the buffer contents and of the last good result
    integer seed;
    tile_t  vec_m [`VEC_BUFS];
    tile_t  mat_m [`TILE_N];
    tile_t  last_result;

    always #20 clk = ~clk;

    exec_unit_top exec_unit_top_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .result  (result),
        .done    (done),
        .err     (err)
    );

    // ========================================
    // Checks
    // ========================================

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_tile(input string name, input tile_t act, input tile_t exp);
        if (act !== exp) begin
            fail_stop($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, act, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            fail_stop($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, act, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
        if (act !== exp) begin
            fail_stop($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, act, exp));
        end
    endtask

    // ========================================
    // APB driver
    // ========================================

    // Setup on one falling edge, access on the next, sampled at the completing rising edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        int waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        @(posedge clk);
        while (!pready) begin
            waits++;
            if (waits > 16) begin
                fail_stop("APB transfer never saw pready");
            end
            @(posedge clk);
        end
        rdata  = prdata;
        slverr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        apb_xfer(1'b0, addr, 32'h0, data, slverr);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            cycles++;
            if (cycles > 50) begin
                fail_stop("Timed out waiting for done");
            end
            @(negedge clk);
        end
    endtask

    // Command word: opcode 4:0, dest 9:8, x 13:12, b 17:16
    function automatic logic [31:0] cmd_word(input opcode_t op, input buf_id_t dest,
                                             input buf_id_t x, input buf_id_t b);
        return {14'b0, b, 2'b0, x, 2'b0, dest, 3'b0, op};
    endfunction

    task automatic load_vec(input buf_id_t idx, input tile_t t);
        logic slverr;
        apb_write(`ADDR_VEC + {4'b0000, idx, 2'b00}, t, slverr);
        check_bit("pslverr", slverr, 1'b0);
        vec_m[idx] = t;
    endtask

    task automatic load_mat(input buf_id_t row, input tile_t t);
        logic slverr;
        apb_write(`ADDR_MAT + {4'b0000, row, 2'b00}, t, slverr);
        check_bit("pslverr", slverr, 1'b0);
        mat_m[row] = t;
    endtask

    task automatic read_vec_check(input buf_id_t idx);
        logic [31:0] data;
        logic        slverr;
        apb_read(`ADDR_VEC + {4'b0000, idx, 2'b00}, data, slverr);
        check_bit("pslverr", slverr, 1'b0);
        check_tile($sformatf("vec[%0d]", idx), tile_t'(data), vec_m[idx]);
    endtask

    task automatic run_cmd(input opcode_t op, input buf_id_t dest, input buf_id_t x,
                           input buf_id_t b);
        logic slverr;
        apb_write(`ADDR_CMD, cmd_word(op, dest, x, b), slverr);
        check_bit("pslverr", slverr, 1'b0);
        wait_done();
        // done lasts a single cycle
        @(negedge clk);
        check_bit("done", done, 1'b0);
    endtask

    `include "exec_tests.svh"

    // ========================================
    // Sequence
    // ========================================

    initial begin
        seed        = 39;
        clk         = 1'b0;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        last_result = '0;
        for (int i = 0; i < `VEC_BUFS; i++) begin
            vec_m[i] = '0;
        end
        for (int r = 0; r < `TILE_N; r++) begin
            mat_m[r] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        test_load_readback();
        test_relu();
        test_gemv();
        test_chain();
        test_errors();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
+incdir+verif
src/exec_pkg.sv
src/tile_bus_if.sv
src/apb_cmd_port.sv
src/buffer_file.sv
src/exec_core.sv
src/result_port.sv
src/exec_unit_top.sv
verif/exec_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = exec_tb
FILELIST = vlog.f
SIM      = obj_dir/V$(TOP)
PASS     = === PASS ===

.PHONY: sim clean

# Build, run, and fail unless the pass message shows up
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir
